//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_instr_tracer
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+.
trace_pkg.sv
trace_slot_ctrl.sv
trace_slot_regs.sv
trace_retire_buf.sv
instr_tracer.sv
tb_instr_tracer_properties.sv
tb_instr_tracer.sv

//--- instr_tracer.sv
/*
 * Instruction retirement tracker
 * Follows each decoded instruction through the EX, EX-delay,
 * WB and WB-delay slots and emits one record per retirement
 */

module instr_tracer import trace_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n,
  input  dec_evt_t   dec_i,
  input  ex_evt_t    ex_i,
  input  wb_evt_t    wb_i,
  output logic       retire_valid_o,
  output trace_rec_t retire_o,
  output logic       overflow_o
);

  slot_t [3:0]   slots;
  slot_cmd_t     cmd;
  retire_mark_t  mark;
  reg_wr_t       ex_wr;
  reg_wr_t       wb_wr;
  logic          overflow_evt;
  logic          alloc_ok;
  trace_id_t     alloc_id;
  retire_class_e wb_delay_class;

  trace_slot_ctrl i_trace_slot_ctrl (
    .dec_i            (dec_i),
    .ex_i             (ex_i),
    .wb_i             (wb_i),
    .slots_i          (slots),
    .alloc_ok_i       (alloc_ok),
    .wb_delay_class_i (wb_delay_class),
    .cmd_o            (cmd),
    .mark_o           (mark),
    .ex_wr_o          (ex_wr),
    .wb_wr_o          (wb_wr),
    .overflow_evt_o   (overflow_evt)
  );

  trace_slot_regs i_trace_slot_regs (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .cmd_i      (cmd),
    .alloc_id_i (alloc_id),
    .slots_o    (slots)
  );

  trace_retire_buf i_trace_retire_buf (
    .clk_i            (clk_i),
    .rst_n            (rst_n),
    .dec_i            (dec_i),
    .alloc_i          (cmd.new_instr),
    .ex_wr_i          (ex_wr),
    .wb_wr_i          (wb_wr),
    .mark_i           (mark),
    .overflow_evt_i   (overflow_evt),
    .wb_slot_id_i     (slots[SLOT_WB].id),
    .alloc_ok_o       (alloc_ok),
    .alloc_id_o       (alloc_id),
    .wb_delay_class_o (wb_delay_class),
    .retire_valid_o   (retire_valid_o),
    .retire_o         (retire_o),
    .overflow_o       (overflow_o)
  );

endmodule

//--- tb_instr_tracer.sv
/*
 * Testbench for the instruction retirement tracker
 * A simple core model drives decode, EX and WB events, and every
 * retired record is compared with a queue of expected records
 */

`include "trace_settings.svh"

module tb_instr_tracer import trace_pkg::*; ();

  logic       clk_i = 1'b0;
  logic       rst_n;
  dec_evt_t   dec;
  ex_evt_t    ex;
  wb_evt_t    wb;
  logic       retire_valid;
  trace_rec_t retire;
  logic       overflow;
  int         errors = 0;
  int         checks = 0;
  integer     seed = 32'h244a_e118;
  integer     r;
  integer     r_instr;
  trace_rec_t exp_q[$];

  always #5 clk_i = ~clk_i;

  instr_tracer i_instr_tracer (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .dec_i          (dec),
    .ex_i           (ex),
    .wb_i           (wb),
    .retire_valid_o (retire_valid),
    .retire_o       (retire),
    .overflow_o     (overflow)
  );

  // --------------------------------------------------
  // Expected records
  // --------------------------------------------------
  task automatic push_expected(logic [31:0] pc, logic [31:0] instr, logic compressed,
                               logic written, logic bypass, logic apu,
                               retire_class_e cls);
    trace_rec_t rec;
    rec              = '0;
    rec.pc           = pc;
    rec.instr        = instr;
    rec.compressed   = compressed;
    rec.rd_written   = written;
    rec.wb_bypass    = bypass;
    rec.is_apu       = apu;
    rec.retire_class = cls;
    if (written) begin
      rec.rd_addr  = instr[11:7];
      rec.rd_value = pc ^ 32'h5a5a_5a5a;
    end
    exp_q.push_back(rec);
  endtask

  // --------------------------------------------------
  // Core model
  // --------------------------------------------------
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle(int n);
    dec = '0;
    ex  = '0;
    wb  = '0;
    repeat (n) next_cycle();
  endtask

  task automatic drive_decode(logic [31:0] pc, logic [31:0] instr, logic compressed);
    dec = '{id_valid: 1'b1, is_decoding: 1'b1, is_illegal: 1'b0, compressed: compressed,
            pc: pc, instr: instr};
  endtask

  task automatic issue(logic [31:0] pc, logic [31:0] instr, logic compressed);
    drive_decode(pc, instr, compressed);
    next_cycle();
    dec = '0;
  endtask

  task automatic write_back(logic [31:0] pc, logic [31:0] instr);
    wb = '{wb_valid: 1'b1, reg_we: 1'b1, reg_addr: instr[11:7],
           reg_wdata: pc ^ 32'h5a5a_5a5a};
    next_cycle();
    wb = '0;
  endtask

  task automatic run_normal(logic [31:0] pc, logic [31:0] instr, logic compressed, int stall,
                            retire_class_e cls);
    push_expected(pc, instr, compressed, 1'b1, 1'b0, 1'b0, cls);
    issue(pc, instr, compressed);
    ex.ex_valid = 1'b1;
    next_cycle();
    ex = '0;
    repeat (stall) next_cycle();
    write_back(pc, instr);
  endtask

  task automatic run_bypass(logic [31:0] pc, logic [31:0] instr);
    push_expected(pc, instr, 1'b0, 1'b0, 1'b1, 1'b0, CLASS_NORMAL);
    issue(pc, instr, 1'b0);
    ex.ex_valid  = 1'b1;
    ex.wb_bypass = 1'b1;
    next_cycle();
    ex = '0;
  endtask

  // APU op goes to EX delay while the next op decodes, then the next op
  // leaves EX on the result cycle and queues behind it
  task automatic run_apu(logic [31:0] pc, int lat);
    push_expected(pc, 32'h0000_0053, 1'b0, 1'b0, 1'b0, 1'b1, CLASS_NORMAL);
    push_expected(pc + 4, 32'h0030_0193, 1'b0, 1'b1, 1'b0, 1'b0, CLASS_NORMAL);
    issue(pc, 32'h0000_0053, 1'b0);
    drive_decode(pc + 4, 32'h0030_0193, 1'b0);
    ex.ex_valid = 1'b1;
    ex.apu_en   = 1'b1;
    next_cycle();
    idle(lat);
    ex.ex_valid   = 1'b1;
    ex.apu_rvalid = 1'b1;
    next_cycle();
    ex          = '0;
    wb.wb_valid = 1'b1;
    next_cycle();
    write_back(pc + 4, 32'h0030_0193);
  endtask

  task automatic wait_drained(int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      next_cycle();
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timeout while waiting for %0d instructions to retire", exp_q.size());
    end
  endtask

  // --------------------------------------------------
  // Retire checker
  // --------------------------------------------------
  always @(negedge clk_i) begin
    trace_rec_t exp_rec;
    if (rst_n && retire_valid) begin
      checks++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("[FAIL] %0t retire with nothing issued, pc %h", $time, retire.pc);
      end else begin
        exp_rec = exp_q.pop_front();
        assert (retire == exp_rec) else begin
          errors++;
          $display("[FAIL] %0t record mismatch, got %h expected %h", $time, retire, exp_rec);
        end
      end
    end
  end

  initial begin
    int n;
    dec   = '0;
    ex    = '0;
    wb    = '0;
    rst_n = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n = 1'b1;
    next_cycle();

    // Directed sequences
    run_normal(32'h0000_0100, 32'h0050_0293, 1'b0, 0, CLASS_NORMAL);
    run_bypass(32'h0000_0104, 32'h0000_0063);
    run_apu(32'h0000_0108, 3);
    run_normal(32'h0000_0110, `INSTR_MRET, 1'b0, 0, CLASS_WB_DELAY);
    run_normal(32'h0000_0114, {16'h0, `INSTR_C_EBREAK}, 1'b1, 1, CLASS_WB_DELAY);
    run_normal(32'h0000_0118, `INSTR_EBREAK, 1'b0, 2, CLASS_WB_DELAY);
    wait_drained(100);

    // Random gaps, stalls and APU latencies
    for (int i = 0; i < 40; i++) begin
      r       = $random(seed);
      r_instr = $random(seed);
      case (r[1:0])
        2'd0, 2'd1: run_normal({r[31:10], 2'b00}, {r_instr[31:7], 7'h13}, 1'b0, r[4:3],
                               CLASS_NORMAL);
        2'd2:       run_bypass({r[31:10], 2'b00}, {r_instr[31:7], 7'h63});
        default:    run_apu({r[31:10], 2'b00}, r[6:3]);
      endcase
      idle(r[8:7]);
    end
    wait_drained(200);

    // Fill the buffer with instructions that never retire
    for (int i = 0; i < `TRACE_DEPTH; i++) begin
      issue(32'h0000_1000 + 4 * i, 32'h0000_0013, 1'b0);
    end
    assert (!overflow) else begin
      errors++;
      $display("[FAIL] %0t overflow set before the buffer was full", $time);
    end
    issue(32'h0000_2000, 32'h0000_0013, 1'b0);
    n = 0;
    while (!overflow && n < 10) begin
      next_cycle();
      n++;
    end
    if (!overflow) begin
      errors++;
      $display("Timeout while waiting for the overflow flag");
    end
    idle(20);
    assert (overflow) else begin
      errors++;
      $display("[FAIL] %0t overflow flag cleared without reset", $time);
    end

    $display("Retire checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             i_instr_tracer.i_props.fail_count);
    if (errors == 0 && i_instr_tracer.i_props.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- tb_instr_tracer_properties.sv
/*
 * Tracer properties
 * Concurrent checks on the tracker ports for the sticky
 * overflow flag, retire class, APU ordering and clean records
 */

`include "trace_settings.svh"

module tb_instr_tracer_properties import trace_pkg::*; (
  input logic       clk_i,
  input logic       rst_n,
  input ex_evt_t    ex_i,
  input logic       retire_valid_o,
  input trace_rec_t retire_o,
  input logic       overflow_o
);

  logic apu_seen;
  logic is_delay_instr;
  int   fail_count = 0;

  // An APU result must arrive before its record can retire
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      apu_seen <= 1'b0;
    end else if (ex_i.apu_rvalid) begin
      apu_seen <= 1'b1;
    end else if (retire_valid_o && retire_o.is_apu) begin
      apu_seen <= 1'b0;
    end
  end

  assign is_delay_instr = retire_o.instr == `INSTR_MRET || retire_o.instr == `INSTR_URET ||
                          retire_o.instr == `INSTR_EBREAK ||
                          (retire_o.compressed && retire_o.instr[15:0] == `INSTR_C_EBREAK);

  overflow_sticky: assert property (@(posedge clk_i) disable iff (!rst_n)
    overflow_o |=> overflow_o)
    else begin
      fail_count++;
      $error("overflow flag dropped without reset");
    end

  record_known: assert property (@(posedge clk_i) disable iff (!rst_n)
    retire_valid_o |-> !$isunknown(retire_o))
    else begin
      fail_count++;
      $error("retired record has unknown bits");
    end

  delay_class: assert property (@(posedge clk_i) disable iff (!rst_n)
    retire_valid_o |->
      (retire_o.retire_class == (is_delay_instr ? CLASS_WB_DELAY : CLASS_NORMAL)))
    else begin
      fail_count++;
      $error("retire class does not match the instruction encoding");
    end

  apu_after_result: assert property (@(posedge clk_i) disable iff (!rst_n)
    retire_valid_o && retire_o.is_apu |-> apu_seen)
    else begin
      fail_count++;
      $error("APU instruction retired before its result");
    end

endmodule

bind instr_tracer tb_instr_tracer_properties i_props (.*);

//--- trace_pkg.sv
/*
 * Instruction tracer types
 * Core event bundles, slot state, per-cycle slot commands,
 * retire marks, routed register writes and the retire record
 */

`include "trace_settings.svh"

package trace_pkg;

  typedef logic [`TRACE_ID_W-1:0] trace_id_t;

  typedef enum logic {
    CLASS_NORMAL,
    CLASS_WB_DELAY
  } retire_class_e;

  // Index into the slot array
  typedef enum logic [1:0] {
    SLOT_EX,
    SLOT_EX_DLY,
    SLOT_WB,
    SLOT_WB_DLY
  } slot_e;

  // ------------------------------------------------
  // Core events
  // ------------------------------------------------
  typedef struct packed {
    logic              id_valid;
    logic              is_decoding;
    logic              is_illegal;
    logic              compressed;
    logic [`XLEN-1:0]  pc;
    logic [`XLEN-1:0]  instr;
  } dec_evt_t;

  typedef struct packed {
    logic                   ex_valid;
    logic                   data_misaligned;
    logic                   wb_bypass;
    logic                   apu_en;
    logic                   apu_rvalid;
    logic                   reg_we;
    logic [`REG_ADDR_W-1:0] reg_addr;
    logic [`XLEN-1:0]       reg_wdata;
  } ex_evt_t;

  typedef struct packed {
    logic                   wb_valid;
    logic                   reg_we;
    logic [`REG_ADDR_W-1:0] reg_addr;
    logic [`XLEN-1:0]       reg_wdata;
  } wb_evt_t;

  // ------------------------------------------------
  // Tracker state and commands
  // ------------------------------------------------
  typedef struct packed {
    logic      valid;
    trace_id_t id;
    logic      is_apu;
    logic      misaligned;
  } slot_t;

  typedef struct packed {
    logic new_instr;
    logic ex_misaligned;
    logic ex_clear;
    logic ex_to_ex_dly;
    logic ex_dly_to_wb;
    logic ex_to_wb;
    logic wb_clear;
    logic wb_to_wb_dly;
    logic wb_dly_clear;
    logic ex_is_apu;
  } slot_cmd_t;

  // EX mark is only raised for WB bypass
  typedef struct packed {
    logic      ex_valid;
    trace_id_t ex_id;
    logic      ex_bypass;
    logic      wb_valid;
    trace_id_t wb_id;
    logic      wb_is_apu;
    logic      wbd_valid;
    trace_id_t wbd_id;
  } retire_mark_t;

  typedef struct packed {
    logic                   valid;
    trace_id_t              id;
    logic [`REG_ADDR_W-1:0] addr;
    logic [`XLEN-1:0]       data;
  } reg_wr_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       instr;
    logic                   compressed;
    logic                   rd_written;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       rd_value;
    logic                   wb_bypass;
    logic                   is_apu;
    retire_class_e          retire_class;
  } trace_rec_t;

endpackage

//--- trace_retire_buf.sv
/*
 * Tracer retire buffer
 * Circular buffer of trace records in program order. Entries
 * collect register writes and retire marks while in flight,
 * and the head drains one done entry per cycle as a strobe.
 * A capture that finds the buffer full sets a sticky flag.
 */

`include "trace_settings.svh"

module trace_retire_buf import trace_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_n,
  input  dec_evt_t      dec_i,
  input  logic          alloc_i,
  input  reg_wr_t       ex_wr_i,
  input  reg_wr_t       wb_wr_i,
  input  retire_mark_t  mark_i,
  input  logic          overflow_evt_i,
  input  trace_id_t     wb_slot_id_i,
  output logic          alloc_ok_o,
  output trace_id_t     alloc_id_o,
  output retire_class_e wb_delay_class_o,
  output logic          retire_valid_o,
  output trace_rec_t    retire_o,
  output logic          overflow_o
);

  trace_rec_t              rec_q [`TRACE_DEPTH];
  logic [`TRACE_DEPTH-1:0] done_q;
  trace_id_t               head_q;
  trace_id_t               tail_q;
  logic [`TRACE_ID_W:0]    count_q;
  logic                    pop;
  retire_class_e           dec_class;

  // mret, uret and ebreak need one extra cycle after WB
  always_comb begin
    dec_class = CLASS_NORMAL;
    if (dec_i.instr == `INSTR_MRET || dec_i.instr == `INSTR_URET ||
        dec_i.instr == `INSTR_EBREAK) begin
      dec_class = CLASS_WB_DELAY;
    end else if (dec_i.compressed && dec_i.instr[15:0] == `INSTR_C_EBREAK) begin
      dec_class = CLASS_WB_DELAY;
    end
  end

  assign alloc_ok_o       = (count_q != `TRACE_DEPTH);
  assign alloc_id_o       = tail_q;
  assign wb_delay_class_o = rec_q[wb_slot_id_i].retire_class;
  assign pop              = (count_q != '0) && done_q[head_q];

  // ------------------------------------------------
  // Pointers, done bits and flags
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      head_q         <= '0;
      tail_q         <= '0;
      count_q        <= '0;
      done_q         <= '0;
      retire_valid_o <= 1'b0;
      overflow_o     <= 1'b0;
    end else begin
      if (alloc_i) begin
        tail_q         <= tail_q + 1'b1;
        done_q[tail_q] <= 1'b0;
      end
      if (mark_i.ex_valid)  done_q[mark_i.ex_id]  <= 1'b1;
      if (mark_i.wb_valid)  done_q[mark_i.wb_id]  <= 1'b1;
      if (mark_i.wbd_valid) done_q[mark_i.wbd_id] <= 1'b1;
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      count_q        <= count_q + alloc_i - pop;
      retire_valid_o <= pop;
      if (overflow_evt_i) begin
        overflow_o <= 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // Record payload
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      rec_q[tail_q] <= '{pc: dec_i.pc, instr: dec_i.instr, compressed: dec_i.compressed,
                         rd_written: 1'b0, rd_addr: '0, rd_value: '0, wb_bypass: 1'b0,
                         is_apu: 1'b0, retire_class: dec_class};
    end
    // WB write comes last so it wins over an EX write to the same entry
    if (ex_wr_i.valid) begin
      rec_q[ex_wr_i.id].rd_written <= 1'b1;
      rec_q[ex_wr_i.id].rd_addr    <= ex_wr_i.addr;
      rec_q[ex_wr_i.id].rd_value   <= ex_wr_i.data;
    end
    if (wb_wr_i.valid) begin
      rec_q[wb_wr_i.id].rd_written <= 1'b1;
      rec_q[wb_wr_i.id].rd_addr    <= wb_wr_i.addr;
      rec_q[wb_wr_i.id].rd_value   <= wb_wr_i.data;
    end
    if (mark_i.ex_valid && mark_i.ex_bypass) begin
      rec_q[mark_i.ex_id].wb_bypass <= 1'b1;
    end
    if (mark_i.wb_valid && mark_i.wb_is_apu) begin
      rec_q[mark_i.wb_id].is_apu <= 1'b1;
    end
    if (pop) begin
      retire_o <= rec_q[head_q];
    end
  end

endmodule

//--- trace_settings.svh
/*
 * Instruction tracer settings
 * Buffer depth, field widths and the opcode encodings that
 * put an instruction in the WB-delay retire class
 */

`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// Retire buffer sizing, depth must be a power of two
`define TRACE_DEPTH 8
`define TRACE_ID_W  3

// Data path widths
`define XLEN        32
`define REG_ADDR_W  5

// Instructions that take one extra cycle to retire
`define INSTR_MRET     32'h3020_0073
`define INSTR_URET     32'h0020_0073
`define INSTR_EBREAK   32'h0010_0073
`define INSTR_C_EBREAK 16'h9002

`endif

//--- trace_slot_ctrl.sv
/*
 * Tracer slot control
 * Decides each cycle which slots advance, clear or retire,
 * and routes EX and WB register writes to the owning buffer id
 */

module trace_slot_ctrl import trace_pkg::*; (
  input  dec_evt_t      dec_i,
  input  ex_evt_t       ex_i,
  input  wb_evt_t       wb_i,
  input  slot_t [3:0]   slots_i,
  input  logic          alloc_ok_i,
  input  retire_class_e wb_delay_class_i,
  output slot_cmd_t     cmd_o,
  output retire_mark_t  mark_o,
  output reg_wr_t       ex_wr_o,
  output reg_wr_t       wb_wr_o,
  output logic          overflow_evt_o
);

  slot_t ex_s;
  slot_t exd_s;
  slot_t wb_s;
  slot_t wbd_s;
  logic  legal;
  slot_e wb_tgt;
  logic  wb_hit;

  assign ex_s  = slots_i[SLOT_EX];
  assign exd_s = slots_i[SLOT_EX_DLY];
  assign wb_s  = slots_i[SLOT_WB];
  assign wbd_s = slots_i[SLOT_WB_DLY];

  assign legal          = dec_i.id_valid && dec_i.is_decoding && !dec_i.is_illegal;
  assign overflow_evt_o = legal && !alloc_ok_i;

  always_comb begin
    cmd_o  = '0;
    mark_o = '0;

    // ------------------------------------------------
    // WB delay, always retires on the next edge
    // ------------------------------------------------
    if (wbd_s.valid) begin
      mark_o.wbd_valid   = 1'b1;
      mark_o.wbd_id      = wbd_s.id;
      cmd_o.wb_dly_clear = 1'b1;
    end

    // ------------------------------------------------
    // WB
    // ------------------------------------------------
    if (wb_s.valid && wb_i.wb_valid) begin
      if (wb_delay_class_i == CLASS_WB_DELAY) begin
        cmd_o.wb_to_wb_dly = 1'b1;
      end else begin
        mark_o.wb_valid  = 1'b1;
        mark_o.wb_id     = wb_s.id;
        mark_o.wb_is_apu = wb_s.is_apu;
        cmd_o.wb_clear   = 1'b1;
      end
    end

    // ------------------------------------------------
    // EX delay, APU waits for its result
    // ------------------------------------------------
    if (exd_s.valid && (ex_i.apu_rvalid || !exd_s.is_apu)) begin
      cmd_o.ex_dly_to_wb = 1'b1;
    end

    // ------------------------------------------------
    // EX
    // ------------------------------------------------
    cmd_o.new_instr = legal && alloc_ok_i;

    if (ex_s.valid && ex_i.ex_valid && ex_i.data_misaligned) begin
      cmd_o.ex_misaligned = 1'b1;
    end else if (ex_s.valid && ex_i.wb_bypass) begin
      mark_o.ex_valid  = 1'b1;
      mark_o.ex_id     = ex_s.id;
      mark_o.ex_bypass = 1'b1;
      cmd_o.ex_clear   = 1'b1;
    end else if (ex_s.valid && ex_i.apu_en && !ex_i.apu_rvalid) begin
      cmd_o.ex_to_ex_dly = 1'b1;
      cmd_o.ex_is_apu    = 1'b1;
      cmd_o.ex_clear     = 1'b1;
    end else if (ex_s.valid && ex_i.ex_valid) begin
      // WB is taken by the EX delay slot this cycle, so queue behind it
      if (cmd_o.ex_dly_to_wb) begin
        cmd_o.ex_to_ex_dly = 1'b1;
      end else begin
        cmd_o.ex_to_wb = 1'b1;
      end
      cmd_o.ex_clear = 1'b1;
    end
  end

  // WB write goes to the oldest slot still able to own it
  always_comb begin
    wb_tgt = SLOT_WB;
    wb_hit = 1'b1;
    if (exd_s.valid) begin
      wb_tgt = SLOT_EX_DLY;
    end else if (wb_s.valid) begin
      wb_tgt = SLOT_WB;
    end else if (ex_s.valid && ex_s.misaligned) begin
      wb_tgt = SLOT_EX;
    end else begin
      wb_hit = 1'b0;
    end
  end

  assign ex_wr_o = '{valid: ex_i.reg_we && ex_s.valid, id: ex_s.id,
                     addr: ex_i.reg_addr, data: ex_i.reg_wdata};
  assign wb_wr_o = '{valid: wb_i.reg_we && wb_hit, id: slots_i[wb_tgt].id,
                     addr: wb_i.reg_addr, data: wb_i.reg_wdata};

endmodule

//--- trace_slot_regs.sv
/*
 * Tracer slot registers
 * Holds the EX, EX-delay, WB and WB-delay slots and moves
 * buffer ids between them as the slot commands direct
 */

module trace_slot_regs import trace_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n,
  input  slot_cmd_t   cmd_i,
  input  trace_id_t   alloc_id_i,
  output slot_t [3:0] slots_o
);

  slot_t [3:0] slots_q;

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      slots_q <= '0;
    end else begin
      // ------------------------------------------------
      // EX
      // ------------------------------------------------
      if (cmd_i.new_instr) begin
        slots_q[SLOT_EX] <= '{valid: 1'b1, id: alloc_id_i, is_apu: 1'b0,
                              misaligned: 1'b0};
      end else if (cmd_i.ex_clear) begin
        slots_q[SLOT_EX] <= '0;
      end else if (cmd_i.ex_misaligned) begin
        slots_q[SLOT_EX].misaligned <= 1'b1;
      end

      // ------------------------------------------------
      // EX delay
      // ------------------------------------------------
      if (cmd_i.ex_to_ex_dly) begin
        slots_q[SLOT_EX_DLY] <= '{valid: 1'b1, id: slots_q[SLOT_EX].id,
                                  is_apu: cmd_i.ex_is_apu, misaligned: 1'b0};
      end else if (cmd_i.ex_dly_to_wb) begin
        slots_q[SLOT_EX_DLY] <= '0;
      end

      // ------------------------------------------------
      // WB
      // ------------------------------------------------
      if (cmd_i.ex_to_wb) begin
        slots_q[SLOT_WB] <= '{valid: 1'b1, id: slots_q[SLOT_EX].id, is_apu: 1'b0,
                              misaligned: 1'b0};
      end else if (cmd_i.ex_dly_to_wb) begin
        slots_q[SLOT_WB] <= slots_q[SLOT_EX_DLY];
      end else if (cmd_i.wb_clear || cmd_i.wb_to_wb_dly) begin
        slots_q[SLOT_WB] <= '0;
      end

      // ------------------------------------------------
      // WB delay
      // ------------------------------------------------
      if (cmd_i.wb_to_wb_dly) begin
        slots_q[SLOT_WB_DLY] <= slots_q[SLOT_WB];
      end else if (cmd_i.wb_dly_clear) begin
        slots_q[SLOT_WB_DLY] <= '0;
      end
    end
  end

  assign slots_o = slots_q;

endmodule
